//--- design/ml_consts.svh
`ifndef ML_CONSTS_SVH
`define ML_CONSTS_SVH

// scratchpad geometry
// block address width, 32K blocks of 64 bytes
`define ML_ADDR_W 15
// one AES-sized lane
`define ML_LANE_W 128
`define ML_LANES 4

// loop length as a power of two
`define ML_ITER_LOG2_FULL 19
`define ML_ITER_LOG2_FAST 6

// cycles from operands to product
`define ML_MUL_DELAY 1

`endif

//--- design/ml_pkg.sv
`default_nettype none

`include "ml_consts.svh"

package ml_pkg;

  // one-hot loop phases
  typedef enum logic [6:0] {
    phase_idle   = 7'b0000001,
    phase_read1  = 7'b0000010,
    phase_aes    = 7'b0000100,
    phase_write1 = 7'b0001000,
    phase_read2  = 7'b0010000,
    phase_mul    = 7'b0100000,
    phase_write2 = 7'b1000000
  } ml_phase_t;

  typedef logic [`ML_LANE_W-1:0] ml_lane_t;
  typedef ml_lane_t [`ML_LANES-1:0] ml_block_t;

  // lane index, byte address bits 5:4
  typedef logic [1:0] ml_lane_sel_t;

  // what a lane means to the loop
  typedef enum logic [1:0] {
    role_cx   = 2'd0,
    role_chk1 = 2'd1,
    role_chk2 = 2'd2,
    role_chk3 = 2'd3
  } ml_role_t;

  // block slot holding a role, permuted by the lane index
  function automatic ml_lane_sel_t lane_slot(input ml_role_t role, input ml_lane_sel_t sel);
    return ml_lane_sel_t'(role) ^ sel;
  endfunction

endpackage

`default_nettype wire

//--- design/ml_step_if.sv
`timescale 1ns/1ps
`default_nettype none

// phase strobes, state machine to datapath
interface ml_step_if
  import ml_pkg::*;
();

  ml_phase_t phase;
  // run start, one cycle in idle
  logic      load;
  // read address valid on addr_next
  logic      rd_issue;
  // ram_rddata holds the block
  logic      rd_done;
  logic      aes_step;
  // write phase about to begin
  logic      wr1;
  logic      wr2;
  logic      mul_done;
  logic      next_iter;
  // level, read2 through write2
  logic      stage2;

  modport fsm (
    output phase, load, rd_issue, rd_done, aes_step,
    output wr1, wr2, mul_done, next_iter, stage2
  );

  modport data (
    input phase, load, rd_issue, rd_done, aes_step,
    input wr1, wr2, mul_done, next_iter, stage2
  );

endinterface

`default_nettype wire

//--- design/ml_phase_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ml_consts.svh"

module ml_phase_fsm
  import ml_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  logic    ctrl_start,
  input  logic    last_loop,
  output logic    sts_running,
  output logic    sts_finished,
  ml_step_if.fsm  step
);

  ml_phase_t              cs;
  ml_phase_t              ns;
  logic                   rd_issue;
  logic                   mul_entry;
  // read completion, entry pulse delayed twice
  logic                   rd_entry_q;
  logic                   rd_done_q;
  // mul completion, entry pulse delayed ML_MUL_DELAY times
  logic [`ML_MUL_DELAY:0] mul_pipe;

  // ========================================
  // phase register
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cs <= phase_idle;
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns = cs;
    case (cs)
      phase_idle:   if (ctrl_start) ns = phase_read1;
      phase_read1:  if (rd_done_q) ns = phase_aes;
      phase_aes:    ns = phase_write1;
      phase_write1: ns = phase_read2;
      phase_read2:  if (rd_done_q) ns = phase_mul;
      phase_mul:    if (mul_pipe[`ML_MUL_DELAY]) ns = phase_write2;
      phase_write2: ns = last_loop ? phase_idle : phase_read1;
      default:      ns = phase_idle;
    endcase
  end

  // entering either read phase
  assign rd_issue  = (ns == phase_read1 || ns == phase_read2) && ns != cs;
  assign mul_entry = ns == phase_mul && cs != phase_mul;

  // ========================================
  // completion timing and status
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_entry_q   <= 1'b0;
      rd_done_q    <= 1'b0;
      mul_pipe     <= '0;
      sts_running  <= 1'b0;
      sts_finished <= 1'b0;
    end else begin
      rd_entry_q   <= rd_issue;
      rd_done_q    <= rd_entry_q;
      mul_pipe     <= {mul_pipe[`ML_MUL_DELAY-1:0], mul_entry};
      // drops together with the finished pulse
      sts_running  <= ns != phase_idle;
      sts_finished <= cs == phase_write2 && last_loop;
    end
  end

  // strobes to the datapath
  assign step.phase     = cs;
  assign step.load      = cs == phase_idle && ctrl_start;
  assign step.rd_issue  = rd_issue;
  assign step.rd_done   = rd_done_q;
  assign step.aes_step  = cs == phase_aes;
  assign step.wr1       = ns == phase_write1 && cs != phase_write1;
  assign step.wr2       = ns == phase_write2 && cs != phase_write2;
  assign step.mul_done  = mul_pipe[`ML_MUL_DELAY];
  assign step.next_iter = cs == phase_write2 && !last_loop;
  assign step.stage2    = cs == phase_read2 || cs == phase_mul || cs == phase_write2;

endmodule

`default_nettype wire

//--- design/ml_iter_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ml_consts.svh"

module ml_iter_counter
  import ml_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  logic    mode_speedup,
  ml_step_if.data step,
  output logic    last_loop
);

  // one spare bit so the limit itself fits
  localparam int cnt_w = `ML_ITER_LOG2_FULL + 1;

  logic [cnt_w-1:0] iter_cnt;
  logic [cnt_w-1:0] iter_limit;
  // speedup mode held for the whole run
  logic             fast_q;

  assign iter_limit = fast_q ? cnt_w'(1) << `ML_ITER_LOG2_FAST
                             : cnt_w'(1) << `ML_ITER_LOG2_FULL;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      iter_cnt  <= '0;
      fast_q    <= 1'b0;
      last_loop <= 1'b0;
    end else if (step.load) begin
      iter_cnt  <= '0;
      fast_q    <= mode_speedup;
      last_loop <= 1'b0;
    end else begin
      // one count per stage-1 block read
      if (step.rd_done && step.phase == phase_read1) begin
        iter_cnt <= iter_cnt + 1'b1;
      end
      // settles long before write2 of the same iteration
      last_loop <= iter_cnt >= iter_limit;
    end
  end

endmodule

`default_nettype wire

//--- design/ml_scratch_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "ml_consts.svh"

module ml_scratch_port
  import ml_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  ml_step_if.data              step,
  input  logic [63:0]          addr_next,
  input  ml_lane_t             wr_cx,
  input  ml_lane_t             wr_chk1,
  input  ml_lane_t             wr_chk2,
  input  ml_lane_t             wr_chk3,
  input  ml_block_t            ram_rddata,
  output ml_block_t            rd_lanes,
  output logic                 ram_rden,
  output logic                 ram_wren,
  output logic [`ML_ADDR_W-1:0] ram_addr,
  output ml_block_t            ram_wrdata
);

  // lane index of the current block
  ml_lane_sel_t lane_sel;
  // write lanes indexed by role
  ml_block_t    wr_roles;
  ml_block_t    wr_block;

  // ========================================
  // address and strobes
  // ========================================
  // address kept for the write back of the same block
  always_ff @(posedge clk) begin
    if (step.rd_issue) begin
      ram_addr <= addr_next[`ML_ADDR_W+5:6];
      lane_sel <= addr_next[5:4];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ram_rden <= 1'b0;
      ram_wren <= 1'b0;
    end else begin
      ram_rden <= step.rd_issue;
      ram_wren <= step.wr1 || step.wr2;
    end
  end

  // ========================================
  // lane packing
  // ========================================
  assign wr_roles = {wr_chk3, wr_chk2, wr_chk1, wr_cx};

  always_comb begin
    wr_block = '0;
    for (int r = 0; r < `ML_LANES; r++) begin
      wr_block[lane_slot(ml_role_t'(r), lane_sel)] = wr_roles[r];
    end
  end

  // write data launched with ram_wren
  always_ff @(posedge clk) begin
    if (step.wr1 || step.wr2) begin
      ram_wrdata <= wr_block;
    end
  end

  // read side, slot back to role
  always_comb begin
    for (int r = 0; r < `ML_LANES; r++) begin
      rd_lanes[r] = ram_rddata[lane_slot(ml_role_t'(r), lane_sel)];
    end
  end

endmodule

`default_nettype wire

//--- design/ml_lane_state.sv
`timescale 1ns/1ps
`default_nettype none

module ml_lane_state
  import ml_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  ml_step_if.data          step,
  input  logic [11:0][63:0] h0,
  input  ml_block_t        rd_lanes,
  input  ml_lane_t         cipher_state_out,
  input  logic [127:0]     product,
  output logic [63:0]      addr_next,
  output ml_lane_t         wr_cx,
  output ml_lane_t         wr_chk1,
  output ml_lane_t         wr_chk2,
  output ml_lane_t         wr_chk3,
  output ml_lane_t         cipher_state_in,
  output ml_lane_t         cipher_roundkey,
  output logic [63:0]      mul_a,
  output logic [63:0]      mul_b
);

  ml_lane_t    seed_ax0;
  ml_lane_t    seed_bx0;
  ml_lane_t    seed_bx1;
  ml_lane_t    ax0;
  ml_lane_t    bx0;
  ml_lane_t    bx1;
  logic [63:0] al0;
  logic [63:0] ah0;
  ml_lane_t    cx;
  // lanes of the last block read
  ml_lane_t    rd_cx;
  ml_lane_t    chk1;
  ml_lane_t    chk2;
  ml_lane_t    chk3;
  logic [63:0] cl;
  logic [63:0] ch;
  logic [63:0] hi;
  logic [63:0] lo;

  // two independent 64-bit adds, no carry across
  function automatic ml_lane_t lane_add(input ml_lane_t x, input ml_lane_t y);
    return {x[127:64] + y[127:64], x[63:0] + y[63:0]};
  endfunction

  // seed from the hash words
  assign seed_ax0 = {h0[1] ^ h0[5], h0[0] ^ h0[4]};
  assign seed_bx0 = {h0[3] ^ h0[7], h0[2] ^ h0[6]};
  assign seed_bx1 = {h0[9] ^ h0[11], h0[8] ^ h0[10]};

  assign cl       = rd_cx[63:0];
  assign ch       = rd_cx[127:64];
  assign {hi, lo} = product;

  // ========================================
  // loop state
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ax0 <= '0;
      bx0 <= '0;
      bx1 <= '0;
      al0 <= '0;
      ah0 <= '0;
    end else if (step.load) begin
      ax0 <= seed_ax0;
      bx0 <= seed_bx0;
      bx1 <= seed_bx1;
      al0 <= seed_ax0[63:0];
      ah0 <= seed_ax0[127:64];
    end else if (step.mul_done) begin
      // high word into the low accumulator
      al0 <= al0 + hi;
      ah0 <= ah0 + lo;
    end else if (step.next_iter) begin
      al0 <= al0 ^ cl;
      ah0 <= ah0 ^ ch;
      ax0 <= {ah0 ^ ch, al0 ^ cl};
      bx0 <= cx;
      bx1 <= bx0;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cx <= '0;
    end else if (step.aes_step) begin
      cx <= cipher_state_out ^ chk1 ^ chk2 ^ chk3;
    end
  end

  // block capture, both stages
  always_ff @(posedge clk) begin
    if (step.rd_done) begin
      rd_cx <= rd_lanes[role_cx];
      chk1  <= rd_lanes[role_chk1];
      chk2  <= rd_lanes[role_chk2];
      chk3  <= rd_lanes[role_chk3];
    end
  end

  // ========================================
  // write lanes and side ports
  // ========================================
  // shuffled sums, each chk lands one slot over
  assign wr_chk1 = lane_add(chk3, bx1);
  assign wr_chk2 = lane_add(chk1, bx0);
  assign wr_chk3 = lane_add(chk2, ax0);
  // stage 1 stores cx mixed with bx0, stage 2 the accumulator
  assign wr_cx = step.stage2 ? {ah0 + lo, al0 + hi}
                             : cipher_state_out ^ chk1 ^ chk2 ^ chk3 ^ bx0;

  // seed on start, cx for stage 2, accumulator for the next loop
  assign addr_next = step.load   ? seed_ax0[63:0] :
                     step.stage2 ? al0 ^ cl : cx[63:0];

  assign cipher_state_in = rd_cx;
  assign cipher_roundkey = {<<8{ax0}};
  assign mul_a           = cx[63:0];
  assign mul_b           = cl;

endmodule

`default_nettype wire

//--- design/ml_mul64.sv
`timescale 1ns/1ps
`default_nettype none

`include "ml_consts.svh"

module ml_mul64 (
  input  logic         clk,
  input  logic [63:0]  a,
  input  logic [63:0]  b,
  output logic [127:0] product
);

  // product pipeline, new operands every cycle
  logic [127:0] mul_q [`ML_MUL_DELAY];

  always_ff @(posedge clk) begin
    mul_q[0] <= a * b;
    for (int i = 1; i < `ML_MUL_DELAY; i++) begin
      mul_q[i] <= mul_q[i-1];
    end
  end

  // hi in 127:64, lo in 63:0
  assign product = mul_q[`ML_MUL_DELAY-1];

endmodule

`default_nettype wire

//--- design/cn_ml_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "ml_consts.svh"

module cn_ml_core
  import ml_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  // run control
  input  logic                 ctrl_start,
  input  logic                 mode_speedup,
  output logic                 sts_running,
  output logic                 sts_finished,
  // hash words from the previous stage
  input  logic [63:0]          h0_0,
  input  logic [63:0]          h0_1,
  input  logic [63:0]          h0_2,
  input  logic [63:0]          h0_3,
  input  logic [63:0]          h0_4,
  input  logic [63:0]          h0_5,
  input  logic [63:0]          h0_6,
  input  logic [63:0]          h0_7,
  input  logic [63:0]          h0_8,
  input  logic [63:0]          h0_9,
  input  logic [63:0]          h0_10,
  input  logic [63:0]          h0_11,
  // scratchpad RAM
  output logic                 ram_rden,
  output logic                 ram_wren,
  output logic [`ML_ADDR_W-1:0] ram_addr,
  output logic [511:0]         ram_wrdata,
  input  logic [511:0]         ram_rddata,
  // AES round, outside
  output logic [127:0]         cipher_state_in,
  output logic [127:0]         cipher_roundkey,
  input  logic [127:0]         cipher_state_out
);

  ml_step_if step ();

  logic         last_loop;
  logic [63:0]  addr_next;
  ml_lane_t     wr_cx;
  ml_lane_t     wr_chk1;
  ml_lane_t     wr_chk2;
  ml_lane_t     wr_chk3;
  ml_block_t    rd_lanes;
  logic [63:0]  mul_a;
  logic [63:0]  mul_b;
  logic [127:0] product;

  ml_phase_fsm i_ml_phase_fsm (
    .clk          (clk),
    .reset_n      (reset_n),
    .ctrl_start   (ctrl_start),
    .last_loop    (last_loop),
    .sts_running  (sts_running),
    .sts_finished (sts_finished),
    .step         (step.fsm)
  );

  ml_iter_counter i_ml_iter_counter (
    .clk          (clk),
    .reset_n      (reset_n),
    .mode_speedup (mode_speedup),
    .step         (step.data),
    .last_loop    (last_loop)
  );

  ml_scratch_port i_ml_scratch_port (
    .clk        (clk),
    .reset_n    (reset_n),
    .step       (step.data),
    .addr_next  (addr_next),
    .wr_cx      (wr_cx),
    .wr_chk1    (wr_chk1),
    .wr_chk2    (wr_chk2),
    .wr_chk3    (wr_chk3),
    .ram_rddata (ram_rddata),
    .rd_lanes   (rd_lanes),
    .ram_rden   (ram_rden),
    .ram_wren   (ram_wren),
    .ram_addr   (ram_addr),
    .ram_wrdata (ram_wrdata)
  );

  ml_lane_state i_ml_lane_state (
    .clk              (clk),
    .reset_n          (reset_n),
    .step             (step.data),
    .h0               ({h0_11, h0_10, h0_9, h0_8, h0_7, h0_6,
                        h0_5, h0_4, h0_3, h0_2, h0_1, h0_0}),
    .rd_lanes         (rd_lanes),
    .cipher_state_out (cipher_state_out),
    .product          (product),
    .addr_next        (addr_next),
    .wr_cx            (wr_cx),
    .wr_chk1          (wr_chk1),
    .wr_chk2          (wr_chk2),
    .wr_chk3          (wr_chk3),
    .cipher_state_in  (cipher_state_in),
    .cipher_roundkey  (cipher_roundkey),
    .mul_a            (mul_a),
    .mul_b            (mul_b)
  );

  ml_mul64 i_ml_mul64 (
    .clk     (clk),
    .a       (mul_a),
    .b       (mul_b),
    .product (product)
  );

endmodule

`default_nettype wire

//--- testbench/tb_cn_ml.sv
`timescale 1ns/1ps
`default_nettype none

`include "ml_consts.svh"

module tb_cn_ml;

  localparam int n_tests = 3;
  // one vector holds mode, twelve h0 words, write count and digest
  localparam int vec_words = 15;
  localparam int blocks = 1 << `ML_ADDR_W;
  localparam int test_cycles = 9 * ((1 << `ML_ITER_LOG2_FAST) + 4);
  // reset and idle checks plus a margin on top of all runs
  localparam int watchdog_ns = 4 * (n_tests * test_cycles + 16 + 200);

  logic           clk;
  logic           reset_n;
  logic           ctrl_start;
  logic           mode_speedup;
  logic [63:0]    h0 [12];
  logic           sts_running;
  logic           sts_finished;
  logic           ram_rden;
  logic           ram_wren;
  logic [14:0]    ram_addr;
  logic [511:0]   ram_wrdata;
  logic [511:0]   ram_rddata;
  logic [127:0]   cipher_state_in;
  logic [127:0]   cipher_roundkey;
  logic [127:0]   cipher_state_out;

  // scratchpad seen by the DUT and the model's own copy
  logic [511:0]   ram [blocks];
  logic [511:0]   model_mem [blocks];
  logic [127:0]   vec_mem [n_tests * vec_words];
  logic [63:0]    h0_v [12];
  integer         seed;
  int             err_count;
  int             total_writes;

  // expected traffic of one run in order
  logic [14:0]    exp_rd_addr_q [$];
  logic [14:0]    exp_wr_addr_q [$];
  logic [511:0]   exp_wr_data_q [$];
  // AES operands per iteration
  logic [127:0]   exp_aes_in_q [$];
  logic [127:0]   exp_aes_key_q [$];
  logic [127:0]   model_digest;

  cn_ml_core i_cn_ml_core (
    .clk              (clk),
    .reset_n          (reset_n),
    .ctrl_start       (ctrl_start),
    .mode_speedup     (mode_speedup),
    .sts_running      (sts_running),
    .sts_finished     (sts_finished),
    .h0_0             (h0[0]),
    .h0_1             (h0[1]),
    .h0_2             (h0[2]),
    .h0_3             (h0[3]),
    .h0_4             (h0[4]),
    .h0_5             (h0[5]),
    .h0_6             (h0[6]),
    .h0_7             (h0[7]),
    .h0_8             (h0[8]),
    .h0_9             (h0[9]),
    .h0_10            (h0[10]),
    .h0_11            (h0[11]),
    .ram_rden         (ram_rden),
    .ram_wren         (ram_wren),
    .ram_addr         (ram_addr),
    .ram_wrdata       (ram_wrdata),
    .ram_rddata       (ram_rddata),
    .cipher_state_in  (cipher_state_in),
    .cipher_roundkey  (cipher_roundkey),
    .cipher_state_out (cipher_state_out)
  );

  // ========================================
  // clock, RAM and AES models
  // ========================================
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // registered read and a write on the wren cycle
  always @(posedge clk) begin
    if (ram_wren) begin
      ram[ram_addr] <= ram_wrdata;
    end
    if (ram_rden) begin
      ram_rddata <= ram[ram_addr];
    end
  end

  // stand-in round that only XORs in the key
  assign cipher_state_out = cipher_state_in ^ cipher_roundkey;

  // ========================================
  // reference loop helpers
  // ========================================
  // slot is role ^ lane index so the same swap packs and unpacks
  function automatic logic [511:0] swap_lanes(input logic [511:0] v, input logic [1:0] sel);
    logic [511:0] out;
    for (int r = 0; r < 4; r++) begin
      out[128 * (r ^ sel) +: 128] = v[128 * r +: 128];
    end
    return out;
  endfunction

  // two 64-bit sums with no carry between halves
  function automatic logic [127:0] add_halves(input logic [127:0] x, input logic [127:0] y);
    return {x[127:64] + y[127:64], x[63:0] + y[63:0]};
  endfunction

  function automatic logic [127:0] byte_reverse(input logic [127:0] x);
    logic [127:0] out;
    for (int i = 0; i < 16; i++) begin
      out[8 * i +: 8] = x[8 * (15 - i) +: 8];
    end
    return out;
  endfunction

  function automatic logic [127:0] xor_lanes(input logic [511:0] blk);
    return blk[127:0] ^ blk[255:128] ^ blk[383:256] ^ blk[511:384];
  endfunction

  task automatic store_write(input logic [14:0] ba, input logic [511:0] blk);
    model_mem[ba] = blk;
    exp_wr_addr_q.push_back(ba);
    exp_wr_data_q.push_back(blk);
    model_digest ^= xor_lanes(blk);
  endtask

  // whole run ahead of the DUT from h0_v
  task automatic build_model(input int n_iter);
    logic [127:0] ax0;
    logic [127:0] bx0;
    logic [127:0] bx1;
    logic [127:0] cx;
    logic [63:0]  al0;
    logic [63:0]  ah0;
    logic [63:0]  addr;
    logic [63:0]  cl;
    logic [63:0]  ch;
    logic [127:0] prod;
    logic [511:0] roles;
    logic [14:0]  ba;
    logic [1:0]   sel;
    exp_rd_addr_q.delete();
    exp_wr_addr_q.delete();
    exp_wr_data_q.delete();
    exp_aes_in_q.delete();
    exp_aes_key_q.delete();
    model_digest = '0;
    ax0 = {h0_v[1] ^ h0_v[5], h0_v[0] ^ h0_v[4]};
    bx0 = {h0_v[3] ^ h0_v[7], h0_v[2] ^ h0_v[6]};
    bx1 = {h0_v[9] ^ h0_v[11], h0_v[8] ^ h0_v[10]};
    al0 = ax0[63:0];
    ah0 = ax0[127:64];
    for (int it = 0; it < n_iter; it++) begin
      // stage 1 on the block at ax0
      addr = ax0[63:0];
      ba = addr[20:6];
      sel = addr[5:4];
      exp_rd_addr_q.push_back(ba);
      roles = swap_lanes(model_mem[ba], sel);
      exp_aes_in_q.push_back(roles[127:0]);
      exp_aes_key_q.push_back(byte_reverse(ax0));
      cx = roles[127:0] ^ byte_reverse(ax0) ^ roles[255:128] ^ roles[383:256] ^ roles[511:384];
      store_write(ba, swap_lanes({add_halves(roles[383:256], ax0), add_halves(roles[255:128], bx0),
                                  add_halves(roles[511:384], bx1), cx ^ bx0}, sel));
      // stage 2 on the block at cx
      addr = cx[63:0];
      ba = addr[20:6];
      sel = addr[5:4];
      exp_rd_addr_q.push_back(ba);
      roles = swap_lanes(model_mem[ba], sel);
      cl = roles[63:0];
      ch = roles[127:64];
      prod = 128'(cx[63:0]) * 128'(cl);
      store_write(ba, swap_lanes({add_halves(roles[383:256], ax0), add_halves(roles[255:128], bx0),
                                  add_halves(roles[511:384], bx1),
                                  ah0 + prod[63:0], al0 + prod[127:64]}, sel));
      // update the accumulator and rotate for the next loop
      al0 = (al0 + prod[127:64]) ^ cl;
      ah0 = (ah0 + prod[63:0]) ^ ch;
      ax0 = {ah0, al0};
      bx1 = bx0;
      bx0 = cx;
    end
  endtask

  // ========================================
  // error reporting
  // ========================================
  task automatic report_value(input string name, input logic [511:0] got,
                              input logic [511:0] exp);
    err_count++;
    $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic report_bit(input string name, input logic got, input logic exp);
    err_count++;
    $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("%0t ns: %s", $time, msg);
  endtask

  // ========================================
  // one run from one vector
  // ========================================
  task automatic run_test(input int t);
    int           base;
    int           n_iter;
    int           cyc;
    int           pos;
    int           writes;
    int           exp_writes;
    logic         done;
    logic         exp_run;
    logic         exp_fin;
    logic         exp_rden;
    logic         exp_wren;
    logic [14:0]  exp_addr;
    logic [511:0] exp_data;
    logic [127:0] exp_lane;
    logic [127:0] file_digest;
    logic [127:0] dut_digest;
    base = t * vec_words;
    for (int i = 0; i < 12; i++) begin
      h0_v[i] = vec_mem[base + 1 + i][63:0];
    end
    exp_writes = int'(vec_mem[base + 13][31:0]);
    file_digest = vec_mem[base + 14];
    n_iter = vec_mem[base][0] ? (1 << `ML_ITER_LOG2_FAST) : (1 << `ML_ITER_LOG2_FULL);
    build_model(n_iter);
    // start pulse with the hash words and mode
    @(posedge clk);
    mode_speedup <= vec_mem[base][0];
    for (int i = 0; i < 12; i++) begin
      h0[i] <= h0_v[i];
    end
    ctrl_start <= 1'b1;
    @(posedge clk);
    ctrl_start <= 1'b0;
    cyc = 0;
    writes = 0;
    done = 1'b0;
    dut_digest = '0;
    while (!done) begin
      @(negedge clk);
      cyc++;
      pos = (cyc - 1) % 9;
      exp_run = cyc <= 9 * n_iter;
      exp_fin = cyc == 9 * n_iter + 1;
      // reads enter at 0 and 4 and writes sit at 3 and 8
      exp_rden = exp_run && (pos == 0 || pos == 4);
      exp_wren = exp_run && (pos == 3 || pos == 8);
      if (sts_running !== exp_run)
        report_bit("sts_running", sts_running, exp_run);
      if (sts_finished !== exp_fin)
        report_bit("sts_finished", sts_finished, exp_fin);
      if (ram_rden !== exp_rden)
        report_bit("ram_rden", ram_rden, exp_rden);
      if (ram_wren !== exp_wren)
        report_bit("ram_wren", ram_wren, exp_wren);
      // AES phase is the third cycle of each iteration
      if (exp_run && pos == 2) begin
        exp_lane = exp_aes_in_q.pop_front();
        if (cipher_state_in !== exp_lane)
          report_value("cipher_state_in", 512'(cipher_state_in), 512'(exp_lane));
        exp_lane = exp_aes_key_q.pop_front();
        if (cipher_roundkey !== exp_lane)
          report_value("cipher_roundkey", 512'(cipher_roundkey), 512'(exp_lane));
      end
      if (ram_rden === 1'b1) begin
        if (exp_rd_addr_q.size() == 0) begin
          report_error("block read beyond the reference model's reads");
        end else begin
          exp_addr = exp_rd_addr_q.pop_front();
          if (ram_addr !== exp_addr)
            report_value("ram_addr on read", 512'(ram_addr), 512'(exp_addr));
        end
      end
      if (ram_wren === 1'b1) begin
        writes++;
        dut_digest ^= xor_lanes(ram_wrdata);
        if (exp_wr_addr_q.size() == 0) begin
          report_error("block write beyond the reference model's writes");
        end else begin
          exp_addr = exp_wr_addr_q.pop_front();
          exp_data = exp_wr_data_q.pop_front();
          if (ram_addr !== exp_addr)
            report_value("ram_addr on write", 512'(ram_addr), 512'(exp_addr));
          if (ram_wrdata !== exp_data)
            report_value("ram_wrdata", ram_wrdata, exp_data);
        end
      end
      if (sts_finished === 1'b1) begin
        done = 1'b1;
      end else if (cyc > 9 * n_iter + 4) begin
        report_error("sts_finished never pulsed after the last write");
        done = 1'b1;
      end
    end
    // pulse is one cycle wide
    @(negedge clk);
    if (sts_finished !== 1'b0)
      report_bit("sts_finished after pulse", sts_finished, 1'b0);
    if (sts_running !== 1'b0)
      report_bit("sts_running after finish", sts_running, 1'b0);
    if (writes != exp_writes)
      report_value("write count", 512'(writes), 512'(exp_writes));
    if (exp_wr_addr_q.size() != 0)
      report_error("DUT made fewer block writes than the reference model");
    if (dut_digest !== model_digest)
      report_value("write digest", 512'(dut_digest), 512'(model_digest));
    if (file_digest != '0 && dut_digest !== file_digest)
      report_value("write digest vs vector file", 512'(dut_digest), 512'(file_digest));
    total_writes += writes;
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    reset_n = 1'b0;
    ctrl_start = 1'b0;
    mode_speedup = 1'b0;
    for (int i = 0; i < 12; i++) begin
      h0[i] = '0;
    end
    ram_rddata = '0;
    err_count = 0;
    total_writes = 0;
    seed = 32'hdbaabab8;
    $readmemh("testbench/ml_vectors.txt", vec_mem);
    // random fill with the block address folded into every word
    for (int a = 0; a < blocks; a++) begin
      for (int w = 0; w < 16; w++) begin
        ram[a][32 * w +: 32] = 32'($random(seed)) ^ 32'(a);
      end
      model_mem[a] = ram[a];
    end
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
    // idle after reset with nothing started
    repeat (3) @(negedge clk);
    if (sts_running !== 1'b0)
      report_bit("sts_running in idle", sts_running, 1'b0);
    if (sts_finished !== 1'b0)
      report_bit("sts_finished in idle", sts_finished, 1'b0);
    if (ram_rden !== 1'b0)
      report_bit("ram_rden in idle", ram_rden, 1'b0);
    if (ram_wren !== 1'b0)
      report_bit("ram_wren in idle", ram_wren, 1'b0);
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("runs: %0d, block writes: %0d, errors: %0d", n_tests, total_writes, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // hang guard over all runs
  initial begin
    #(watchdog_ns);
    $display("timeout: runs did not end within %0d ns", watchdog_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/ml_vectors.txt
// columns: mode_speedup h0_0..h0_3 / h0_4..h0_7 / h0_8..h0_11 / block writes, write digest
// a digest of 0 leaves the digest check to the testbench reference model
1 0123456789abcdef fedcba9876543210 0f1e2d3c4b5a6978 8796a5b4c3d2e1f0
a5a5a5a55a5a5a5a 3c3c3c3cc3c3c3c3 1122334455667788 99aabbccddeeff00
deadbeefcafef00d 0badc0de8badf00d 7766554433221100 ffeeddccbbaa9988
80 0
1 6a09e667f3bcc908 bb67ae8584caa73b 3c6ef372fe94f82b a54ff53a5f1d36f1
510e527fade682d1 9b05688c2b3e6c1f 1f83d9abfb41bd6b 5be0cd19137e2179
428a2f98d728ae22 7137449123ef65cd b5c0fbcfec4d3b2f e9b5dba58189dbbc
80 0
1 0 0 0 0
0 0 0 0
0 0 0 0
80 0

//--- tb.f
+incdir+design
design/ml_pkg.sv
design/ml_step_if.sv
design/ml_phase_fsm.sv
design/ml_iter_counter.sv
design/ml_scratch_port.sv
design/ml_lane_state.sv
design/ml_mul64.sv
design/cn_ml_core.sv
testbench/tb_cn_ml.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cn_ml -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cn_ml)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
